// ==== common/mazePkg.sv ====
package mazePkg;

	// screen coordinate, unsigned
	typedef logic [9:0] coordT;

	// per-frame velocity, bit 9 gives the direction
	typedef logic signed [9:0] velT;

	// reduced raster, visible area
	localparam int ScreenWidth = 64;
	localparam int ScreenHeight = 48;

	// full scan including blanking
	localparam int LineTotal = 72;
	localparam int FrameTotal = 52;

	// 8 by 8 pixel tiles
	localparam int TileShift = 3;

	// maze geometry in tiles
	localparam int MazeCols = 8;
	localparam int MazeRows = 6;
	localparam int MazeRowsStored = 8;

	// half size of the ball
	localparam int BallSize = 2;

	typedef struct packed
	{
		coordT x;
		coordT y;
	} pointT;

	typedef struct packed
	{
		velT xVel;
		velT yVel;
	} motionT;

	// wall bits of a tile and its four neighbours
	typedef struct packed
	{
		logic here;
		logic up;
		logic down;
		logic left;
		logic right;
	} mazeBitsT;

	// at most one flag is set at a time
	typedef struct packed
	{
		logic bottom;
		logic top;
		logic left;
		logic right;
	} wallT;

	typedef enum logic [1:0]
	{
		Idle,
		WaitFrame,
		Update
	} ctrlStateT;

endpackage

// ==== hw/scanCounter.sv ====
module scanCounter import mazePkg::*;
(
	input  logic  Reset,
	input  logic  frame_clk,
	output pointT drawPos,
	output logic  frameStart,
	output logic  frameEnd
);

	coordT colNext;
	coordT lineNext;
	logic  lineWrap;

	// next scan position, counters run through blanking too
	always_comb
	begin
		lineWrap = (drawPos.x == coordT'(LineTotal - 1));
		colNext = lineWrap ? '0 : drawPos.x + 10'd1;
		if (!lineWrap)
			lineNext = drawPos.y;
		else if (drawPos.y == coordT'(FrameTotal - 1))
			lineNext = '0;
		else
			lineNext = drawPos.y + 10'd1;
	end

	always_ff @(posedge Reset or negedge frame_clk)
	begin
		if (!frame_clk)
		begin
			drawPos <= '0;
			frameStart <= 1'b0;
			frameEnd <= 1'b0;
		end
		else
		begin
			drawPos.x <= colNext;
			drawPos.y <= lineNext;
			// strobes registered together with the position they mark
			frameStart <= (colNext == '0) && (lineNext == '0);
			frameEnd <= (colNext == coordT'(LineTotal - 1)) &&
				(lineNext == coordT'(FrameTotal - 1));
		end
	end

	assert property (@(posedge Reset) disable iff (!frame_clk)
		!(frameStart && frameEnd));

	// a new frame always starts right after the last position
	assert property (@(posedge Reset) disable iff (!frame_clk)
		frameEnd |=> frameStart);

endmodule

// ==== maze/mazeRom.sv ====
module mazeRom import mazePkg::*;
(
	input  pointT    drawPos,
	output mazeBitsT mazeBits
);

	// one word per tile row, column 0 sits in the top bit
	logic [MazeCols-1:0] mazeMem [MazeRowsStored];

	int tileRow;
	int tileCol;

	initial
	begin
		$readmemh("maze/mazeMap.hex", mazeMem);
	end

	// tiles off the used map read as wall
	function automatic logic tileAt(input int row, input int col);
		logic isWall;
		if (row < 0 || row >= MazeRows || col < 0 || col >= MazeCols)
			isWall = 1'b1;
		else
			isWall = mazeMem[row[2:0]][MazeCols - 1 - col];
		return isWall;
	endfunction

	always_comb
	begin
		tileRow = int'(drawPos.y >> TileShift);
		tileCol = int'(drawPos.x >> TileShift);

		mazeBits.here = tileAt(tileRow, tileCol);
		mazeBits.up = tileAt(tileRow - 1, tileCol);
		mazeBits.down = tileAt(tileRow + 1, tileCol);
		mazeBits.left = tileAt(tileRow, tileCol - 1);
		mazeBits.right = tileAt(tileRow, tileCol + 1);
	end

endmodule

// ==== collision/probeSampler.sv ====
module probeSampler import mazePkg::*;
(
	input  logic     Reset,
	input  logic     frame_clk,
	input  pointT    drawPos,
	input  mazeBitsT mazeBits,
	input  pointT    ballPos,
	input  logic     frameStart,
	input  logic     frameEnd,
	output mazeBitsT heldBits,
	output logic     frameDone
);

	mazeBitsT captBits;
	logic     atBall;

	// scan point sits on the ball centre
	assign atBall = (drawPos == ballPos);

	always_ff @(posedge Reset or negedge frame_clk)
	begin
		if (!frame_clk)
		begin
			captBits <= '0;
			heldBits <= '0;
			frameDone <= 1'b0;
		end
		else
		begin
			// the ball's own pixel wins over the frame start clear
			if (atBall)
				captBits <= mazeBits;
			else if (frameStart)
				captBits <= '0;

			// handed over at frame end and held for the whole next frame
			if (frameEnd)
				heldBits <= atBall ? mazeBits : captBits;

			frameDone <= frameEnd;
		end
	end

	assert property (@(posedge Reset) disable iff (!frame_clk)
		frameEnd |=> frameDone);

endmodule

// ==== collision/wallClassifier.sv ====
module wallClassifier import mazePkg::*;
(
	input  mazeBitsT heldBits,
	input  pointT    ballPos,
	input  motionT   motion,
	output wallT     wall
);

	logic edgeBottom;
	logic edgeTop;
	logic edgeLeft;
	logic edgeRight;
	logic vertWall;
	logic horzWall;

	always_comb
	begin
		// screen edges, measured from the ball rim
		edgeBottom = (ballPos.y + BallSize) >= (ScreenHeight - 1);
		edgeTop = ballPos.y <= BallSize;
		edgeLeft = ballPos.x <= BallSize;
		edgeRight = (ballPos.x + BallSize) >= (ScreenWidth - 1);

		// ball inside a wall tile, which way does the wall run
		vertWall = heldBits.here && (heldBits.up || heldBits.down);
		horzWall = heldBits.here && (heldBits.left || heldBits.right);
	end

	always_comb
	begin
		wall = '0;
		if (edgeBottom)
			wall.bottom = 1'b1;
		else if (edgeTop)
			wall.top = 1'b1;
		else if (edgeLeft)
			wall.left = 1'b1;
		else if (edgeRight)
			wall.right = 1'b1;
		else if (vertWall)
		begin
			// sign bit picks the face the ball is heading into
			if (motion.yVel[9])
				wall.top = 1'b1;
			else
				wall.bottom = 1'b1;
		end
		else if (horzWall)
		begin
			if (motion.xVel[9])
				wall.left = 1'b1;
			else
				wall.right = 1'b1;
		end
	end

	// ballControl relies on a single flag per frame
	always_comb
	begin
		assert ($onehot0(wall));
	end

endmodule

// ==== hw/ballControl.sv ====
module ballControl import mazePkg::*;
(
	input  logic   Reset,
	input  logic   frame_clk,
	input  logic   start,
	input  pointT  startPos,
	input  motionT startVel,
	input  logic   frameDone,
	input  wallT   wall,
	output pointT  ballPos,
	output motionT motion
);

	ctrlStateT state;
	motionT    nextMotion;

	// bounce off whatever the last frame reported
	always_comb
	begin
		nextMotion = motion;
		if (wall.top || wall.bottom)
			nextMotion.yVel = -motion.yVel;
		if (wall.left || wall.right)
			nextMotion.xVel = -motion.xVel;
	end

	always_ff @(posedge Reset or negedge frame_clk)
	begin
		if (!frame_clk)
		begin
			state <= Idle;
			ballPos <= '0;
			motion <= '0;
		end
		else
		begin
			case (state)
				Idle:
				begin
					// follow the start inputs until released
					ballPos <= startPos;
					motion <= startVel;
					if (start)
						state <= WaitFrame;
				end
				WaitFrame:
				begin
					if (frameDone)
						state <= start ? Update : Idle;
				end
				Update:
				begin
					motion <= nextMotion;
					// position moves by the already bounced velocity
					ballPos.x <= ballPos.x + coordT'(nextMotion.xVel);
					ballPos.y <= ballPos.y + coordT'(nextMotion.yVel);
					state <= WaitFrame;
				end
				default:
				begin
					state <= Idle;
				end
			endcase
		end
	end

	assert property (@(posedge Reset) disable iff (!frame_clk)
		(state == Update) |=> (state == WaitFrame));

endmodule

// ==== hw/mazeTop.sv ====
module mazeTop import mazePkg::*;
(
	input  logic   Reset,
	input  logic   frame_clk,
	input  logic   start,
	input  pointT  startPos,
	input  motionT startVel,
	output pointT  ballPos,
	output motionT motion,
	output wallT   wall,
	output logic   frameDone
);

	pointT    drawPos;
	logic     frameStart;
	logic     frameEnd;
	mazeBitsT mazeBits;
	mazeBitsT heldBits;

	scanCounter scanCounter_i
	(
		.Reset      (Reset),
		.frame_clk  (frame_clk),
		.drawPos    (drawPos),
		.frameStart (frameStart),
		.frameEnd   (frameEnd)
	);

	mazeRom mazeRom_i
	(
		.drawPos  (drawPos),
		.mazeBits (mazeBits)
	);

	probeSampler probeSampler_i
	(
		.Reset      (Reset),
		.frame_clk  (frame_clk),
		.drawPos    (drawPos),
		.mazeBits   (mazeBits),
		.ballPos    (ballPos),
		.frameStart (frameStart),
		.frameEnd   (frameEnd),
		.heldBits   (heldBits),
		.frameDone  (frameDone)
	);

	wallClassifier wallClassifier_i
	(
		.heldBits (heldBits),
		.ballPos  (ballPos),
		.motion   (motion),
		.wall     (wall)
	);

	ballControl ballControl_i
	(
		.Reset     (Reset),
		.frame_clk (frame_clk),
		.start     (start),
		.startPos  (startPos),
		.startVel  (startVel),
		.frameDone (frameDone),
		.wall      (wall),
		.ballPos   (ballPos),
		.motion    (motion)
	);

endmodule

// ==== bench/tbChecks.svh ====
// compare tasks, one per result type

task automatic checkPoint(input string name, input pointT got, input pointT exp);
	if (got !== exp)
	begin
		$display("ERR %s got %h expected %h", name, got, exp);
		$display("Regression failed");
		$fatal(1);
	end
endtask

task automatic checkMotion(input string name, input motionT got, input motionT exp);
	if (got !== exp)
	begin
		$display("ERR %s got %h expected %h", name, got, exp);
		$display("Regression failed");
		$fatal(1);
	end
endtask

task automatic checkWall(input string name, input wallT got, input wallT exp);
	if (got !== exp)
	begin
		$display("ERR %s got %h expected %h", name, got, exp);
		$display("Regression failed");
		$fatal(1);
	end
endtask

// sampled on the falling edge, away from the driving edge
task automatic waitFrameDone();
	do
		@(negedge Reset);
	while (!frameDone);
endtask

// one frame handover, checks the flag and the step that follows
task automatic runFrame(input logic expectUpdate);
	wallT expWall;
	waitFrameDone();
	checkPoint("ballPos", ballPos, modelPos);
	expWall = expectWall(modelPos, modelVel, heldFor(modelPos));
	checkWall("wall", wall, expWall);
	if (expectUpdate)
	begin
		if (expWall.top || expWall.bottom)
			modelVel.yVel = -modelVel.yVel;
		if (expWall.left || expWall.right)
			modelVel.xVel = -modelVel.xVel;
		modelPos.x = modelPos.x + coordT'(modelVel.xVel);
		modelPos.y = modelPos.y + coordT'(modelVel.yVel);
		repeat (2) @(negedge Reset);
		checkPoint("ballPos", ballPos, modelPos);
		checkMotion("motion", motion, modelVel);
	end
	else
	begin
		// frozen for one cycle, then back in Idle
		@(negedge Reset);
		checkPoint("ballPos", ballPos, modelPos);
		checkMotion("motion", motion, modelVel);
		@(negedge Reset);
		checkPoint("ballPos", ballPos, startPos);
		checkMotion("motion", motion, startVel);
		modelPos = startPos;
		modelVel = startVel;
	end
endtask

// ==== bench/tbMazeTop.sv ====
module tbMazeTop import mazePkg::*;
();

	// frames used by all tests with some spare
	localparam int TestFrames = 60;
	localparam int FrameCycles = LineTotal * FrameTotal;

	logic   Reset;
	logic   frame_clk;
	logic   start;
	pointT  startPos;
	motionT startVel;
	pointT  ballPos;
	motionT motion;
	wallT   wall;
	logic   frameDone;

	logic [7:0] tbMap [8];
	pointT  modelPos;
	motionT modelVel;

	mazeTop dut_i
	(
		.Reset     (Reset),
		.frame_clk (frame_clk),
		.start     (start),
		.startPos  (startPos),
		.startVel  (startVel),
		.ballPos   (ballPos),
		.motion    (motion),
		.wall      (wall),
		.frameDone (frameDone)
	);

	// anything off the six used rows reads as wall
	function automatic logic isWall(input int row, input int col);
		if (row < 0 || row > 5 || col < 0 || col > 7)
			return 1'b1;
		return tbMap[row][7 - col];
	endfunction

	function automatic mazeBitsT heldFor(input pointT p);
		mazeBitsT b;
		int r;
		int c;
		r = int'(p.y) / 8;
		c = int'(p.x) / 8;
		b.here = isWall(r, c);
		b.up = isWall(r - 1, c);
		b.down = isWall(r + 1, c);
		b.left = isWall(r, c - 1);
		b.right = isWall(r, c + 1);
		return b;
	endfunction

	// screen edges first, then vertical walls, then horizontal walls
	function automatic wallT expectWall(input pointT p, input motionT v, input mazeBitsT h);
		wallT w;
		int x;
		int y;
		w = '0;
		x = int'(p.x);
		y = int'(p.y);
		if (y + BallSize >= ScreenHeight - 1)
			w.bottom = 1'b1;
		else if (y <= BallSize)
			w.top = 1'b1;
		else if (x <= BallSize)
			w.left = 1'b1;
		else if (x + BallSize >= ScreenWidth - 1)
			w.right = 1'b1;
		else if (h.here && (h.up || h.down))
		begin
			if (v.yVel < 0)
				w.top = 1'b1;
			else
				w.bottom = 1'b1;
		end
		else if (h.here && (h.left || h.right))
		begin
			if (v.xVel < 0)
				w.left = 1'b1;
			else
				w.right = 1'b1;
		end
		return w;
	endfunction

	function automatic pointT mkPoint(input int x, input int y);
		pointT p;
		p.x = coordT'(x);
		p.y = coordT'(y);
		return p;
	endfunction

	function automatic motionT mkVel(input int vx, input int vy);
		motionT m;
		m.xVel = velT'(vx);
		m.yVel = velT'(vy);
		return m;
	endfunction

	`include "tbChecks.svh"

	// park in Idle for a full frame before the release
	task automatic launchBall(input pointT pos, input motionT vel);
		@(posedge Reset);
		start <= 1'b0;
		startPos <= pos;
		startVel <= vel;
		waitFrameDone();
		checkPoint("ballPos", ballPos, pos);
		@(posedge Reset);
		start <= 1'b1;
		repeat (2) @(negedge Reset);
		modelPos = pos;
		modelVel = vel;
	endtask

	task automatic stopBall(input pointT nextPos, input motionT nextVel);
		@(posedge Reset);
		start <= 1'b0;
		startPos <= nextPos;
		startVel <= nextVel;
		runFrame(1'b0);
	endtask

	task automatic testAfterReset();
		int cycles;
		cycles = 0;
		@(negedge Reset);
		@(negedge Reset);
		while (!frameDone)
		begin
			checkPoint("ballPos", ballPos, startPos);
			checkMotion("motion", motion, startVel);
			checkWall("wall", wall, '0);
			cycles++;
			@(negedge Reset);
		end
		// scan runs from 0,0 one position per cycle up to the frame end
		if (cycles != FrameCycles - 1)
		begin
			$display("frameDone did not arrive at the end of the first frame");
			$display("Regression failed");
			$fatal(1);
		end
	endtask

	task automatic testFreeMotion();
		motionT v;
		for (int i = 0; i < 3; i++)
		begin
			v = mkVel(int'($urandom_range(4)) - 2, int'($urandom_range(4)) - 2);
			launchBall(mkPoint(28, 12), v);
			repeat (3) runFrame(1'b1);
			stopBall(mkPoint(28, 12), v);
		end
	endtask

	task automatic bounceOnce(input pointT pos, input motionT vel);
		launchBall(pos, vel);
		runFrame(1'b1);
		stopBall(pos, vel);
	endtask

	task automatic testScreenEdges();
		bounceOnce(mkPoint(30, 45), mkVel(0, 1));
		bounceOnce(mkPoint(30, 2), mkVel(0, -1));
		bounceOnce(mkPoint(2, 20), mkVel(-1, 0));
		bounceOnce(mkPoint(61, 20), mkVel(1, 0));
		// bottom beats left in the corner
		bounceOnce(mkPoint(2, 45), mkVel(-1, 1));
	endtask

	task automatic testMazeWalls();
		bounceOnce(mkPoint(44, 20), mkVel(0, -1));
		bounceOnce(mkPoint(44, 20), mkVel(0, 1));
		bounceOnce(mkPoint(20, 36), mkVel(-1, 0));
		bounceOnce(mkPoint(20, 36), mkVel(1, 0));
	endtask

	task automatic testStartDropped();
		launchBall(mkPoint(24, 28), mkVel(1, -1));
		repeat (2) runFrame(1'b1);
		stopBall(mkPoint(36, 12), mkVel(2, 2));
	endtask

	initial
	begin
		Reset = 1'b0;
		forever #5 Reset = ~Reset;
	end

	initial
	begin
		#(TestFrames * FrameCycles * 10 + 1000);
		$display("watchdog: the tests did not finish in time");
		$display("Regression failed");
		$fatal(1);
	end

	initial
	begin
		void'($urandom(78240));
		$readmemh("maze/mazeMap.hex", tbMap);
		frame_clk = 1'b0;
		start = 1'b0;
		startPos = mkPoint(20, 12);
		startVel = mkVel(1, 1);
		repeat (2) @(posedge Reset);
		frame_clk <= 1'b1;
		testAfterReset();
		testFreeMotion();
		testScreenEdges();
		testMazeWalls();
		testStartDropped();
		$display("Regression passed");
		$finish;
	end

endmodule

// ==== maze/mazeMap.hex ====
// one tile row per line, eight tiles per row, column 0 in the top bit
// rows 6 and 7 are stored but lie outside the used map
00
04
04
04
70
00
00
00

// ==== compile.f ====
+incdir+bench
common/mazePkg.sv
hw/scanCounter.sv
maze/mazeRom.sv
collision/probeSampler.sv
collision/wallClassifier.sv
hw/ballControl.sv
hw/mazeTop.sv
bench/tbMazeTop.sv

// ==== run.sh ====
#!/bin/sh
# build and run the maze core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
	--top-module tbMazeTop -f compile.f -o simv
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/simv > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^Regression passed$" sim.log; then
	exit 0
fi
exit 1
